// File: project.f
+incdir+src
src/vid_fmt_pkg.sv
src/pix_pkg.sv
src/raster_if.sv
src/fmt_select.sv
src/raster_timing.sv
src/video_out.sv
src/video_top.sv
tests/video_asserts.sv
tests/tb_video_top.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_video_top -f project.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "No errors" "$LOG"; then
	exit 0
fi
exit 1

// File: src/fmt_select.sv
`timescale 1ns/100ps
`include "video_defs.svh"

module fmt_select (
	input  logic                     clk50m_bufg,
	input  logic                     RSTBTN,
	input  logic [3:0]               sw,
	output vid_fmt_pkg::vid_timing_t timing,
	output logic                     restart,
	output vid_fmt_pkg::vid_fmt_e    led
);

	localparam int DEB_W = $clog2(`VID_DEBOUNCE_CYCLES);
	localparam logic [DEB_W-1:0] DEB_LAST = DEB_W'(`VID_DEBOUNCE_CYCLES - 1);

	logic [3:0]       sw_meta;   // First synchronizer stage
	logic [3:0]       sw_sync;
	logic [3:0]       sw_last;   // Code being timed
	logic [DEB_W-1:0] deb_cnt;   // Cycles sw_sync has matched sw_last
	logic             accept;

	//////////////////////////////////////////////////
	// Synchronizer and debounce
	//////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= sw;
			sw_sync <= sw;
			sw_last <= sw;
			deb_cnt <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			if (sw_sync != sw_last) begin
				sw_last <= sw_sync;
				deb_cnt <= DEB_W'(1);   // Change cycle counts as the first
			end else if (deb_cnt != DEB_LAST) begin
				deb_cnt <= deb_cnt + 1'b1;
			end
		end
	end

	// Full window seen, sw_sync still on the same code
	assign accept = (deb_cnt == DEB_LAST) && (sw_sync == sw_last);

	//////////////////////////////////////////////////
	// Active format
	//////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			led     <= vid_fmt_pkg::vid_fmt_e'(sw);   // Format seen at reset
			timing  <= vid_fmt_pkg::fmt_timing(vid_fmt_pkg::vid_fmt_e'(sw));
			restart <= 1'b0;
		end else begin
			restart <= 1'b0;
			if (accept && (sw_last != led)) begin
				// Raw code kept on led, unknown codes map to 720p timing
				led     <= vid_fmt_pkg::vid_fmt_e'(sw_last);
				timing  <= vid_fmt_pkg::fmt_timing(vid_fmt_pkg::vid_fmt_e'(sw_last));
				restart <= 1'b1;                  // Single pulse per change
			end
		end
	end

endmodule

// File: src/pix_pkg.sv
`include "video_defs.svh"

package pix_pkg;

	// Left to right across the line
	typedef enum logic [2:0] {
		BAR_WHITE,
		BAR_YELLOW,
		BAR_CYAN,
		BAR_GREEN,
		BAR_MAGENTA,
		BAR_RED,
		BAR_BLUE,
		BAR_BLACK
	} bar_e;

	typedef struct packed {
		logic [`VID_COLOR_W-1:0] red;
		logic [`VID_COLOR_W-1:0] green;
		logic [`VID_COLOR_W-1:0] blue;
	} rgb_t;

	// Index bits select channel off: bit2 green, bit1 red, bit0 blue
	function automatic rgb_t bar_rgb(input bar_e bar);
		rgb_t px;
		px.red   = {`VID_COLOR_W{~bar[1]}};
		px.green = {`VID_COLOR_W{~bar[2]}};
		px.blue  = {`VID_COLOR_W{~bar[0]}};
		return px;
	endfunction

endpackage

// File: src/raster_if.sv
`timescale 1ns/100ps
`include "video_defs.svh"

// Raster position and decoded flags, valid every cycle
interface raster_if;

	logic [`VID_CNT_W-1:0] hcount;  // Pixel within line
	logic [`VID_CNT_W-1:0] vcount;  // Line within frame
	logic                  hblnk;
	logic                  vblnk;
	logic                  hsync_raw;   // Active high, before polarity
	logic                  vsync_raw;

	// Timing generator side
	modport src (
		output hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw
	);

	// Output stage side
	modport snk (
		input hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw
	);

endinterface

// File: src/raster_timing.sv
`timescale 1ns/100ps
`include "video_defs.svh"

module raster_timing (
	input  logic                     clk50m_bufg,
	input  logic                     RSTBTN,
	input  vid_fmt_pkg::vid_timing_t timing,
	input  logic                     restart,
	raster_if.src                    ras
);

	logic [`VID_CNT_W-1:0] hcnt;
	logic [`VID_CNT_W-1:0] vcnt;
	logic                  line_end;
	logic                  frame_end;

	// Compare with >= so a shorter format never runs past its limit
	assign line_end  = (hcnt >= timing.heblnk);
	assign frame_end = (vcnt >= timing.veblnk);

	//////////////////////////////////////////////////
	// Pixel and line counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcnt <= '0;                 // New format starts at top left
			vcnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			vcnt <= frame_end ? '0 : vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	assign ras.hcount = hcnt;
	assign ras.vcount = vcnt;

	//////////////////////////////////////////////////
	// Blank and sync decode
	//////////////////////////////////////////////////

	// Past the last active column / line
	assign ras.hblnk = (hcnt > timing.hsblnk);
	assign ras.vblnk = (vcnt > timing.vsblnk);

	// Between end of front porch and last sync position
	assign ras.hsync_raw = (hcnt > timing.hssync) && (hcnt <= timing.hesync);
	assign ras.vsync_raw = (vcnt > timing.vssync) && (vcnt <= timing.vesync);

endmodule

// File: src/vid_fmt_pkg.sv
`include "video_defs.svh"

package vid_fmt_pkg;

	// Switch codes, same encoding as the board switches
	typedef enum logic [3:0] {
		FMT_VGA    = 4'b0000,
		FMT_SVGA   = 4'b0001,
		FMT_720P   = 4'b0010,
		FMT_XGA    = 4'b0011,
		FMT_SXGA   = 4'b1000,
		FMT_CAMERA = 4'b1001
	} vid_fmt_e;

	// Boundaries are last column / last line of each region
	typedef struct packed {
		logic [`VID_CNT_W-1:0] hsblnk;  // Last active column
		logic [`VID_CNT_W-1:0] hssync;  // Last front porch column
		logic [`VID_CNT_W-1:0] hesync;  // Last sync column
		logic [`VID_CNT_W-1:0] heblnk;  // Last column of line
		logic [`VID_CNT_W-1:0] vsblnk;
		logic [`VID_CNT_W-1:0] vssync;
		logic [`VID_CNT_W-1:0] vesync;
		logic [`VID_CNT_W-1:0] veblnk;
		logic [`VID_CNT_W-1:0] bar_w;   // Pixels per colour bar
		logic                  neg_pol; // Active low sync
	} vid_timing_t;

	localparam logic [`VID_CNT_W-1:0] NUM_BARS = `VID_NUM_BARS;

	// Running sums of active/fp/pulse/bp, minus one
	function automatic vid_timing_t mk_timing(
		input logic [`VID_CNT_W-1:0] hp, hfp, hpw, hbp,
		input logic [`VID_CNT_W-1:0] vl, vfp, vpw, vbp,
		input logic                  neg
	);
		vid_timing_t t;
		t.hsblnk  = hp - 1'b1;
		t.hssync  = t.hsblnk + hfp;
		t.hesync  = t.hssync + hpw;
		t.heblnk  = t.hesync + hbp;
		t.vsblnk  = vl - 1'b1;
		t.vssync  = t.vsblnk + vfp;
		t.vesync  = t.vssync + vpw;
		t.veblnk  = t.vesync + vbp;
		t.bar_w   = hp / NUM_BARS;
		t.neg_pol = neg;
		return t;
	endfunction

	function automatic vid_timing_t fmt_timing(input vid_fmt_e fmt);
		case (fmt)
			FMT_VGA:    return mk_timing(640, 16, 96, 48, 480, 11, 2, 31, 1'b1);
			FMT_SVGA:   return mk_timing(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);
			FMT_XGA:    return mk_timing(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);
			FMT_SXGA:   return mk_timing(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0);
			FMT_CAMERA: return mk_timing(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);
			default:    return mk_timing(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0); // 720p, also unknown codes
		endcase
	endfunction

endpackage

// File: src/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

//////////////////////////////////////////////////
// Raster geometry
//////////////////////////////////////////////////

// Pixel and line counters, every timing value
`define VID_CNT_W 11

// Bars across one active line
`define VID_NUM_BARS 8

//////////////////////////////////////////////////
// Pixel data and switch input
//////////////////////////////////////////////////

`define VID_COLOR_W 8           // Per channel

// Cycles the synced switch code must hold still
`define VID_DEBOUNCE_CYCLES 16

`endif

// File: src/video_out.sv
`timescale 1ns/100ps
`include "video_defs.svh"

module video_out (
	input  logic                    clk50m_bufg,
	input  logic                    RSTBTN,
	raster_if.snk                   ras,
	input  logic                    neg_pol,
	input  logic [`VID_CNT_W-1:0]   bar_w,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    de,
	output logic [`VID_COLOR_W-1:0] red,
	output logic [`VID_COLOR_W-1:0] green,
	output logic [`VID_COLOR_W-1:0] blue
);

	logic [`VID_CNT_W-1:0] bar_pix;     // Pixels into current bar
	logic [`VID_CNT_W-1:0] cur_pix;
	pix_pkg::bar_e         bar_idx;
	pix_pkg::bar_e         cur_idx;
	logic                  active;
	logic                  hs_q;
	logic                  vs_q;
	logic                  de_q;
	pix_pkg::rgb_t         rgb_q;

	assign active = !ras.hblnk && !ras.vblnk;

	// Column 0 always opens on white, also right after a restart
	assign cur_pix = (ras.hcount == '0) ? '0 : bar_pix;
	assign cur_idx = (ras.hcount == '0) ? pix_pkg::BAR_WHITE : bar_idx;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || ras.hblnk) begin
			bar_pix <= '0;
			bar_idx <= pix_pkg::BAR_WHITE;
		end else if (cur_pix == bar_w - 1'b1) begin
			bar_pix <= '0;                               // Next bar
			bar_idx <= pix_pkg::bar_e'(cur_idx + 3'd1);
		end else begin
			bar_pix <= cur_pix + 1'b1;
			bar_idx <= cur_idx;
		end
	end

	//////////////////////////////////////////////////
	// Two stage output pipe
	//////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hs_q  <= neg_pol;                  // Inactive level
			vs_q  <= neg_pol;
			de_q  <= 1'b0;
			rgb_q <= '0;
			hsync <= neg_pol;
			vsync <= neg_pol;
			de    <= 1'b0;
			{red, green, blue} <= '0;
		end else begin
			hs_q  <= ras.hsync_raw ^ neg_pol;  // Stage one
			vs_q  <= ras.vsync_raw ^ neg_pol;
			de_q  <= active;
			rgb_q <= active ? pix_pkg::bar_rgb(cur_idx) : '0;
			hsync <= hs_q;                     // Stage two, onto the ports
			vsync <= vs_q;
			de    <= de_q;
			{red, green, blue} <= rgb_q;
		end
	end

endmodule

// File: src/video_top.sv
`timescale 1ns/100ps
`include "video_defs.svh"

module video_top (
	input  logic                    clk50m_bufg,
	input  logic                    RSTBTN,
	input  logic [3:0]              sw,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    de,
	output logic [`VID_COLOR_W-1:0] red,
	output logic [`VID_COLOR_W-1:0] green,
	output logic [`VID_COLOR_W-1:0] blue,
	output logic [3:0]              led
);

	vid_fmt_pkg::vid_timing_t timing;    // Active format limits
	logic                     restart;   // Format change pulse

	raster_if u_ras ();

	// Switches to format and timing record
	fmt_select u_fmt_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.timing      (timing),
		.restart     (restart),
		.led         (led)
	);

	raster_timing u_raster_timing (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.timing      (timing),
		.restart     (restart),
		.ras         (u_ras.src)
	);

	// Polarity, colour bars, two cycle alignment
	video_out u_video_out (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.ras         (u_ras.snk),
		.neg_pol     (timing.neg_pol),
		.bar_w       (timing.bar_w),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

endmodule

// File: tests/tb_video_top.sv
`timescale 1ns/100ps
`include "video_defs.svh"

module tb_video_top;

	//////////////////////////////////////////////////
	// Expected timing, VGA SVGA XGA 720p SXGA camera, then unknown 0111
	//////////////////////////////////////////////////
	localparam logic [3:0] CODE [7] = '{4'h0, 4'h1, 4'h3, 4'h2, 4'h8, 4'h9, 4'h7};
	localparam int H_ACT [7] = '{640, 800, 1024, 1280, 1280, 1280, 1280};
	localparam int H_FP [7]  = '{16, 40, 24, 110, 48, 110, 110};
	localparam int H_PW [7]  = '{96, 128, 136, 40, 112, 39, 40};
	localparam int H_BP [7]  = '{48, 88, 160, 220, 248, 220, 220};
	localparam int V_ACT [7] = '{480, 600, 768, 720, 1024, 720, 720};
	localparam int V_FP [7]  = '{11, 1, 3, 5, 1, 4, 5};
	localparam int V_PW [7]  = '{2, 4, 6, 5, 3, 4, 5};
	localparam int V_BP [7]  = '{31, 23, 29, 20, 38, 22, 20};
	localparam logic NEG [7] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
	localparam logic [23:0] BARS [8] = '{24'hFFFFFF, 24'hFFFF00, 24'h00FFFF, 24'h00FF00,
		24'hFF00FF, 24'hFF0000, 24'h0000FF, 24'h000000};   // Standard bar order
	// Three VGA frames plus debounce and four SXGA lines per format, twice over
	localparam int LIMIT_CYC = 2 * (3 * 800 * 524 + 6 * (`VID_DEBOUNCE_CYCLES + 4 * 1688));

	logic                    clk50m_bufg;
	logic                    RSTBTN;
	logic [3:0]              sw;
	logic                    hsync, vsync, de;
	logic [`VID_COLOR_W-1:0] red, green, blue;
	logic [3:0]              led;
	int                      errors = 0;
	logic [31:0]             lcg_state = 32'd85107;
	logic [2:0]              cur;        // Format the checks expect
	logic                    armed;      // Measurements trusted for cur
	logic                    rst_done;
	logic                    hs_prev, vs_prev, de_prev;
	logic                    hs_seen, vs_seen, de_seen;   // Full pulse seen while armed
	int                      hs_cnt, hs_wid, de_run, frame_lines, de_lines, vs_wid;
	int                      hs_rises, vs_rises;
	logic                    hs_act, vs_act, hs_rise, vs_rise, de_rise;
	int                      h_tot, v_tot, bar_w;

	assign hs_act  = hsync ^ NEG[cur];   // Active sync as a high level
	assign vs_act  = vsync ^ NEG[cur];
	assign hs_rise = hs_act && !hs_prev;
	assign vs_rise = vs_act && !vs_prev;
	assign de_rise = de && !de_prev;
	assign h_tot   = H_ACT[cur] + H_FP[cur] + H_PW[cur] + H_BP[cur];
	assign v_tot   = V_ACT[cur] + V_FP[cur] + V_PW[cur] + V_BP[cur];
	assign bar_w   = H_ACT[cur] / `VID_NUM_BARS;

	video_top u_video_top (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.led         (led)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	task automatic check_eq(input string name, input int got, input int exp);
		assert (got == exp) else begin
			errors++;
			$display("** Error %s: got %0h, expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// Rising edges, then off the edge by 2 ns
	task automatic step(input int n);
		repeat (n) @(posedge clk50m_bufg);
		#2;
	endtask

	//////////////////////////////////////////////////
	// Reference counters and checks
	//////////////////////////////////////////////////
	always @(posedge clk50m_bufg) begin
		hs_prev     <= hs_act;
		vs_prev     <= vs_act;
		de_prev     <= de;
		hs_cnt      <= hs_rise ? 1 : hs_cnt + 1;      // Cycles since sync start
		hs_wid      <= hs_act ? hs_wid + 1 : 0;
		de_run      <= de ? de_run + 1 : 0;           // Pixel index in the run
		frame_lines <= vs_rise ? 0 : frame_lines + int'(hs_rise);
		de_lines    <= vs_rise ? 0 : de_lines + int'(de_rise);
		vs_wid      <= vs_rise ? 0 : vs_wid + int'(hs_rise && vs_act);
		if (rst_done && !de)
			check_eq("rgb", int'({red, green, blue}), 0);
		if (!armed) begin
			{hs_seen, vs_seen, de_seen} <= 3'b000;
			hs_rises <= 0;
			vs_rises <= 0;
		end else begin
			if (hs_rise && hs_seen)
				check_eq("hsync period", hs_cnt, h_tot);
			if (hs_prev && !hs_act && hs_seen)
				check_eq("hsync width", hs_wid, H_PW[cur]);
			if (de_prev && !de && de_seen)
				check_eq("de run", de_run, H_ACT[cur]);
			if (vs_rise && vs_seen) begin
				check_eq("frame lines", frame_lines, v_tot);
				check_eq("de lines", de_lines, V_ACT[cur]);
			end
			if (vs_prev && !vs_act && vs_seen)
				check_eq("vsync width", vs_wid, V_PW[cur]);
			if (de && (de_seen || de_rise)) begin
				check_eq("rgb", int'({red, green, blue}), int'(BARS[3'(de_run / bar_w)]));
				check_eq("hsync", int'(hsync), int'(NEG[cur]));   // Idle level
				check_eq("vsync", int'(vsync), int'(NEG[cur]));
			end
			hs_seen  <= hs_seen || hs_rise;
			vs_seen  <= vs_seen || vs_rise;
			de_seen  <= de_seen || de_rise;
			hs_rises <= hs_rises + int'(hs_rise);
			vs_rises <= vs_rises + int'(vs_rise);
		end
	end

	// Short glitch first, then a real switch and a few checked lines
	task automatic select_format(input logic [2:0] idx);
		int len;
		len = 1 + int'(lcg_next() % 32'd12);
		sw = CODE[idx];
		step(len);
		sw = CODE[cur];
		repeat (4 * `VID_DEBOUNCE_CYCLES) begin
			step(1);
			check_eq("led", int'(led), int'(CODE[cur]));   // Glitch ignored
		end
		armed = 1'b0;
		cur = idx;
		sw = CODE[idx];
		wait (led == CODE[idx]);
		step(h_tot);                                    // Line cut by restart
		armed = 1'b1;
		wait (hs_rises >= 3);
		step(1);
	endtask

	initial begin
		#(LIMIT_CYC * 20);
		$display("Timeout: the run did not finish in the expected time");
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [2:0] order [7];
		logic [2:0] i;
		logic [2:0] j;
		logic [2:0] tmp;
		RSTBTN = 1'b1;
		sw = 4'h0;
		cur = 3'd0;
		armed = 1'b0;
		rst_done = 1'b0;
		order = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6};
		for (i = 3'd6; i > 3'd1; i--) begin   // Shuffle entries 1 to 6
			j = 3'd1 + 3'(lcg_next() % 32'(i));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		step(4);
		RSTBTN = 1'b0;
		rst_done = 1'b1;
		repeat (2) begin                      // First two cycles out of reset
			check_eq("de", int'(de), 0);
			check_eq("hsync", int'(hsync), 1);
			check_eq("vsync", int'(vsync), 1);
			check_eq("led", int'(led), 0);
			step(1);
		end
		armed = 1'b1;
		wait (vs_rises >= 2);                   // One whole VGA frame measured
		step(1);
		for (i = 3'd1; i < 3'd7; i++)
			select_format(order[i]);
		$display("Checks failed: %0d", errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: tests/video_asserts.sv
`timescale 1ns/100ps
`include "video_defs.svh"

// Bound into video_top, watches the raster and the output pipe
module video_asserts (
	input logic                  clk50m_bufg,
	input logic                  RSTBTN,
	input logic                  restart,
	input logic [`VID_CNT_W-1:0] hcount,
	input logic [`VID_CNT_W-1:0] heblnk,
	input logic                  blank,     // Raw hblnk or vblnk
	input logic                  de
);

	logic [1:0] blank_d;   // Same depth as the output pipe

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			blank_d <= 2'b00;
		end else begin
			blank_d <= {blank_d[0], blank};
		end
	end

	restart_one_cycle: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		restart |=> !restart)
		else $error("restart stayed high for more than one cycle");

	// Counter clears on the edge after restart
	hcount_in_line: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!restart |-> (hcount <= heblnk))
		else $error("hcount ran past the last column of the line");

	de_not_in_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		blank_d[1] |-> !de)
		else $error("de high while the delayed blanking flag is set");

endmodule

bind video_top video_asserts u_video_asserts (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.restart     (restart),
	.hcount      (u_ras.hcount),
	.heblnk      (timing.heblnk),
	.blank       (u_ras.hblnk | u_ras.vblnk),
	.de          (de)
);
